/* Makefile */
# Verilator build and run of the Toeplitz hash testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_accel_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables:"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) LOG=$(LOG)"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
logic/accel_pkg.sv
logic/toeplitz_byte.sv
logic/hash_acc.sv
logic/hash_regs.sv
logic/accel_top.sv
verification/tb_accel_top.sv

/* logic/accel_pkg.sv */
package accel_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and hash widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [21:0]  io_addr_t;
  typedef logic [31:0]  io_data_t;
  typedef logic [31:0]  hash_t;

  // length code of a feed, where 0 stands for a full 4-byte word.
  typedef logic [1:0]   hash_len_t;

  typedef logic [5:0]   byte_cnt_t;
  typedef logic [319:0] key_t;

  ////////////////////////////////////////////////////////////////////////////
  // Key and limits
  ////////////////////////////////////////////////////////////////////////////

  // the usual RSS key with its most significant byte first.
  localparam key_t TOEPLITZ_KEY = {
    160'h6d5a56da_255b0ec2_4167253d_43a38fb0_d0ca2bcb,
    160'hae7b30b4_77cb2da3_8030f20c_6a42b73b_beac01fa
  };

  // bytes at this offset and beyond run off the end of the key.
  localparam byte_cnt_t HASH_BYTES = 6'd36;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] REG_CLEAR = 8'h00;
  localparam logic [7:0] REG_FEED1 = 8'h04;
  localparam logic [7:0] REG_FEED2 = 8'h08;
  localparam logic [7:0] REG_FEED4 = 8'h0C;

  // command from the register decoder to the accumulator.
  typedef struct packed {
    io_data_t  data;
    hash_len_t len;
    logic      feed;
    logic      clear;
  } hash_cmd_t;

endpackage

/* logic/accel_top.sv */
`timescale 1ns/10ps

module accel_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                io_en,
  input  logic                io_wen,
  input  accel_pkg::io_addr_t io_addr,
  input  accel_pkg::io_data_t io_wr_data,
  output accel_pkg::io_data_t io_rd_data,
  output logic                io_rd_valid
);

  // decoder to accumulator command, and the hash fed back for reads.
  accel_pkg::hash_cmd_t cmd;
  accel_pkg::hash_t     hash_out;

  ////////////////////////////////////////////////////////////////////////////
  // Register decoder
  ////////////////////////////////////////////////////////////////////////////

  hash_regs u_hash_regs (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .cmd         (cmd),
    .hash_out    (hash_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Toeplitz accumulator
  ////////////////////////////////////////////////////////////////////////////

  hash_acc u_hash_acc (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .hash_out (hash_out)
  );

endmodule

/* logic/hash_acc.sv */
`timescale 1ns/10ps

module hash_acc (
  input  logic                 clk,
  input  logic                 rst,
  input  accel_pkg::hash_cmd_t cmd,
  output accel_pkg::hash_t     hash_out
);

  accel_pkg::hash_t     hash_q;
  accel_pkg::byte_cnt_t cnt_q;
  accel_pkg::key_t      key_q;

  logic [2:0]           feed_bytes;
  logic [3:0]           lane_en;
  accel_pkg::hash_t     lane_part [4];
  accel_pkg::hash_t     feed_part;
  accel_pkg::byte_cnt_t cnt_sum;
  accel_pkg::byte_cnt_t cnt_next;
  accel_pkg::key_t      key_next;

  ////////////////////////////////////////////////////////////////////////////
  // Feed length
  ////////////////////////////////////////////////////////////////////////////

  // a length code of zero means the whole word.
  always_comb begin
    if (cmd.len == 2'd0) begin
      feed_bytes = 3'd4;
    end else begin
      feed_bytes = {1'b0, cmd.len};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////////////////////

  // lane k takes byte k of the word, lowest byte first, and sees the window
  // as it will stand once the k bytes before it have been consumed.
  for (genvar k = 0; k < 4; k++) begin : g_lane
    toeplitz_byte u_lane (
      .data_byte (cmd.data[8*k +: 8]),
      .key_win   (key_q[319-8*k -: 39]),
      .part      (lane_part[k])
    );

    // a byte only counts when it is part of this feed and still lies before
    // the end of the key.
    assign lane_en[k] = (3'(k) < feed_bytes) &&
                        ((cnt_q + 6'(k)) < accel_pkg::HASH_BYTES);
  end

  always_comb begin
    feed_part = '0;
    for (int k = 0; k < 4; k++) begin
      if (lane_en[k]) begin
        feed_part = feed_part ^ lane_part[k];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Count and window advance
  ////////////////////////////////////////////////////////////////////////////

  assign cnt_sum = cnt_q + {3'b000, feed_bytes};

  always_comb begin
    if (cnt_sum > accel_pkg::HASH_BYTES) begin
      cnt_next = accel_pkg::HASH_BYTES;
    end else begin
      cnt_next = cnt_sum;
    end
  end

  // zeros come in from the bottom as the window slides towards the key tail.
  assign key_next = key_q << {feed_bytes, 3'b000};

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || cmd.clear) begin
      hash_q <= '0;
      cnt_q  <= '0;
      key_q  <= accel_pkg::TOEPLITZ_KEY;
    end else if (cmd.feed) begin
      hash_q <= hash_q ^ feed_part;
      cnt_q  <= cnt_next;
      key_q  <= key_next;
    end
  end

  assign hash_out = hash_q;

endmodule

/* logic/hash_regs.sv */
`timescale 1ns/10ps

module hash_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 io_en,
  input  logic                 io_wen,
  input  accel_pkg::io_addr_t  io_addr,
  input  accel_pkg::io_data_t  io_wr_data,
  output accel_pkg::io_data_t  io_rd_data,
  output logic                 io_rd_valid,
  output accel_pkg::hash_cmd_t cmd,
  input  accel_pkg::hash_t     hash_out
);

  logic                wr_strobe;
  logic                rd_strobe;
  logic [7:0]          wr_offset;

  accel_pkg::io_data_t rd_data_q;
  logic                rd_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////////////////////////////////////////

  assign wr_strobe = io_en && io_wen;
  assign rd_strobe = io_en && !io_wen;

  // only the word offset within the low address byte selects a register.
  assign wr_offset = {io_addr[7:2], 2'b00};

  ////////////////////////////////////////////////////////////////////////////
  // Command register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    cmd.feed  <= 1'b0;
    cmd.clear <= 1'b0;

    if (wr_strobe) begin
      cmd.data <= io_wr_data;
      case (wr_offset)
        accel_pkg::REG_CLEAR: begin
          cmd.clear <= 1'b1;
        end
        accel_pkg::REG_FEED1: begin
          cmd.len  <= 2'd1;
          cmd.feed <= 1'b1;
        end
        accel_pkg::REG_FEED2: begin
          cmd.len  <= 2'd2;
          cmd.feed <= 1'b1;
        end
        accel_pkg::REG_FEED4: begin
          cmd.len  <= 2'd0;
          cmd.feed <= 1'b1;
        end
        default: begin
          // unmapped offsets produce no pulse.
        end
      endcase
    end

    if (rst) begin
      cmd.feed  <= 1'b0;
      cmd.clear <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read return
  ////////////////////////////////////////////////////////////////////////////

  // every read returns the hash regardless of the address.
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      rd_data_q <= hash_out;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_strobe;
    end
  end

  assign io_rd_data  = rd_data_q;
  assign io_rd_valid = rd_valid_q;

endmodule

/* logic/toeplitz_byte.sv */
`timescale 1ns/10ps

module toeplitz_byte (
  input  logic [7:0]       data_byte,
  input  logic [38:0]      key_win,
  output accel_pkg::hash_t part
);

  // one masked key slice per input bit.
  accel_pkg::hash_t term [8];
  accel_pkg::hash_t fold;

  ////////////////////////////////////////////////////////////////////////////
  // Bit terms
  ////////////////////////////////////////////////////////////////////////////

  // bit 7 is the first bit of the byte on the wire, so it lines up with the
  // top 32 bits of the window. Each following bit moves the slice down by one.
  for (genvar i = 0; i < 8; i++) begin : g_bit
    assign term[i] = data_byte[i] ? key_win[i +: 32] : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // XOR fold
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    fold = '0;
    for (int i = 7; i >= 0; i--) begin
      fold = fold ^ term[i];
    end
  end

  assign part = fold;

endmodule

/* verification/hash_patterns.txt */
// bus operations for the Toeplitz hash testbench, four hex columns:
//   ctl  addr  data  expect
// ctl 1 = write then idle gap, 3 = write with the next operation on the
// next cycle, 2 = read and compare with expect, 0 = end of the list.

// reset state, any read address
2 000000 00000000 00000000
2 3ffffc 00000000 00000000
// a single first bit selects the top key window
1 000004 00000080 00000000
2 000000 00000000 6d5a56da
1 000000 ffffffff 00000000
2 000000 00000000 00000000
// 66.9.149.187:2794 -> 161.142.100.80:1766, unmapped writes in between
1 00000c bb950942 00000000
1 00000c 50648ea1 00000000
1 000010 ffffffff 00000000
1 3c0020 a5a5a5a5 00000000
1 0000fc 12345678 00000000
2 000000 00000000 323e8fc2
1 00000c e606ea0a 00000000
2 000040 00000000 51ccc178
// clear, then the same tuple again
1 000000 ffffffff 00000000
2 000000 00000000 00000000
1 00000c bb950942 00000000
1 00000c 50648ea1 00000000
1 00000c e606ea0a 00000000
2 000000 00000000 51ccc178
// 199.92.111.2:14230 -> 65.69.140.83:4739, full words
1 000000 00000000 00000000
1 00000c 026f5cc7 00000000
1 00000c 538c4541 00000000
2 000000 00000000 d718262a
1 00000c 83129637 00000000
2 000000 00000000 c626b0ea
// same stream in 1, 2 and 4 byte pieces with junk in unused bytes
1 000000 00000000 00000000
1 000004 ffffffc7 00000000
1 000008 a5a56f5c 00000000
1 00000c 8c454102 00000000
1 000004 00000053 00000000
2 000000 00000000 d718262a
1 000008 00009637 00000000
1 000004 12121212 00000000
1 000004 00000083 00000000
2 000000 00000000 c626b0ea
// 24.19.198.95:12898 -> 12.22.207.184:38024, high address bits set
1 000000 00000000 00000000
1 000008 00001318 00000000
1 3f0008 00005fc6 00000000
1 000008 0000160c 00000000
1 000008 0000b8cf 00000000
2 000000 00000000 d2d0a5de
1 000008 00006232 00000000
1 100008 00008894 00000000
2 000000 00000000 5c2b394a
// 38.27.205.30:48228 -> 209.142.163.6:2217, back to back
3 000000 00000000 00000000
3 00000c 1ecd1b26 00000000
3 00000c 06a38ed1 00000000
1 00000c a90864bc 00000000
2 000000 00000000 afc7327f
// 153.39.163.191:44251 -> 202.188.127.2:1303, back to back, mixed
3 000000 00000000 00000000
3 000004 00000099 00000000
3 000008 0000a327 00000000
3 00000c 7fbccabf 00000000
3 000004 00000002 00000000
1 00000c 1705dbac 00000000
2 000000 00000000 10e828a2
// tuple padded with zeros to 36 bytes, later bytes have no effect
1 000000 00000000 00000000
1 00000c bb950942 00000000
1 00000c 50648ea1 00000000
1 00000c e606ea0a 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
1 00000c 00000000 00000000
2 000000 00000000 51ccc178
1 00000c ffffffff 00000000
1 000004 000000ff 00000000
1 000008 0000ffff 00000000
2 000000 00000000 51ccc178
// last bit of byte 35 counts, bytes 36 and 37 in the same word do not
1 000000 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
3 00000c 00000000 00000000
1 000008 00000000 00000000
1 00000c ffff0100 00000000
2 000000 00000000 df5600fd
1 00000c ffffffff 00000000
2 000000 00000000 df5600fd
0 000000 00000000 00000000

/* verification/tb_accel_top.sv */
`timescale 1ns/10ps

module tb_accel_top;

  localparam int CLK_HALF   = 10;
  localparam int MAX_OPS    = 128;
  localparam int RD_TIMEOUT = 10;

  // operation codes in the first column of the pattern file.
  localparam logic [31:0] CTL_END   = 32'h0;
  localparam logic [31:0] CTL_WRITE = 32'h1;
  localparam logic [31:0] CTL_READ  = 32'h2;
  localparam logic [31:0] CTL_BURST = 32'h3;

  logic                clk;
  logic                rst;
  logic                io_en;
  logic                io_wen;
  accel_pkg::io_addr_t io_addr;
  accel_pkg::io_data_t io_wr_data;
  accel_pkg::io_data_t io_rd_data;
  logic                io_rd_valid;

  // each operation takes four words in the order ctl, addr, data and expected read value.
  logic [31:0] pat [4*MAX_OPS];

  integer seed;
  int     n_reads;
  int     n_data_errors;
  int     n_valid_errors;
  logic   rd_pending;

  accel_top u_accel_top (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read valid monitor
  ////////////////////////////////////////////////////////////////////////////

  // io_rd_valid must follow the read strobe of the previous cycle exactly.
  always @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else begin
      if (io_rd_valid !== rd_pending) begin
        $display("** Error: io_rd_valid expected 0x%0h, got 0x%0h at %0t",
                 rd_pending, io_rd_valid, $time);
        n_valid_errors = n_valid_errors + 1;
      end
      rd_pending <= io_en && !io_wen;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_bus(input accel_pkg::io_addr_t addr,
                           input accel_pkg::io_data_t data);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_addr    <= addr;
    io_wr_data <= data;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      io_en  <= 1'b0;
      io_wen <= 1'b0;
    end
  endtask

  task automatic read_check(input accel_pkg::io_addr_t addr,
                            input accel_pkg::hash_t    exp_hash,
                            input int                  op,
                            output logic               timed_out);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b0;
    io_addr    <= addr;
    io_wr_data <= '0;
    @(posedge clk);
    io_en <= 1'b0;
    while (!got && waited < RD_TIMEOUT) begin
      @(posedge clk);
      waited = waited + 1;
      if (io_rd_valid === 1'b1) begin
        got = 1'b1;
      end
    end
    timed_out = !got;
    if (!got) begin
      $display("timeout: io_rd_valid did not rise within %0d cycles of read %0d",
               RD_TIMEOUT, op);
    end else begin
      n_reads = n_reads + 1;
      if (io_rd_data !== exp_hash) begin
        $display("** Error: io_rd_data expected 0x%08h, got 0x%08h at operation %0d",
                 exp_hash, io_rd_data, op);
        n_data_errors = n_data_errors + 1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Pattern replay
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          idx;
    int          gap;
    logic [31:0] ctl;
    logic        stop;
    logic        timed_out;
    idx            = 0;
    gap            = 0;
    stop           = 1'b0;
    timed_out      = 1'b0;
    seed           = 32'h2a7;
    n_reads        = 0;
    n_data_errors  = 0;
    n_valid_errors = 0;
    rst            = 1'b1;
    io_en          = 1'b0;
    io_wen         = 1'b0;
    io_addr        = '0;
    io_wr_data     = '0;
    for (int i = 0; i < 4*MAX_OPS; i++) begin
      pat[i] = '0;
    end
    $readmemh("verification/hash_patterns.txt", pat);

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    idle_cycles(2);

    while (!stop && idx < MAX_OPS) begin
      ctl = pat[4*idx];
      case (ctl)
        CTL_WRITE, CTL_BURST: begin
          write_bus(pat[4*idx+1][21:0], pat[4*idx+2]);
          // a burst write lets the next operation start on the next cycle.
          if (ctl == CTL_WRITE) begin
            gap = 2 + ($random(seed) & 3);
            idle_cycles(gap);
          end
        end
        CTL_READ: begin
          read_check(pat[4*idx+1][21:0], pat[4*idx+3], idx, timed_out);
          if (timed_out) begin
            n_data_errors = n_data_errors + 1;
            stop = 1'b1;
          end else begin
            gap = 2 + ($random(seed) & 3);
            idle_cycles(gap);
          end
        end
        CTL_END: begin
          stop = 1'b1;
        end
        default: begin
          $display("pattern operation %0d has an unknown code 0x%0h", idx, ctl);
          n_data_errors = n_data_errors + 1;
          stop = 1'b1;
        end
      endcase
      idx = idx + 1;
    end

    if (n_reads == 0) begin
      $display("no read was checked, the pattern file is empty or missing");
      n_data_errors = n_data_errors + 1;
    end

    // a few quiet cycles so that a stray io_rd_valid is still seen.
    idle_cycles(4);
    $display("reads checked: %0d, data errors: %0d, valid errors: %0d",
             n_reads, n_data_errors, n_valid_errors);
    if (n_data_errors == 0 && n_valid_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
